// File: include/dtm_defs.svh
// Widths and fixed register fields of the JTAG DTM, included by the package and the RTL blocks
`ifndef DTM_DEFS_SVH
`define DTM_DEFS_SVH

//--------------------------------------------------------------------------
// Register widths
//--------------------------------------------------------------------------
`define DTM_IR_W      5             // Instruction register
`define DTM_ABITS     7             // DMI address
`define DTM_DATA_W    32            // DMI data

//--------------------------------------------------------------------------
// Fixed values
//--------------------------------------------------------------------------
`define DTM_IDCODE    32'h2BE0_04C3 // Bit 0 set as JTAG requires
`define DTM_IDLE_HINT 5             // Run-Test/Idle cycles to avoid busy
`define DTM_VERSION   1             // Debug spec 0.13

`endif

// File: rtl/dtm_pkg.sv
// Shared enums and packed structs of the JTAG DTM, referenced by scoped name from every block
`default_nettype none
`include "dtm_defs.svh"

package dtm_pkg;

    // Sixteen TAP states, reset state first
    typedef enum logic [3:0] {
        ST_TEST_LOGIC_RESET,
        ST_RUN_TEST_IDLE,
        ST_SELECT_DR_SCAN,
        ST_CAPTURE_DR,
        ST_SHIFT_DR,
        ST_EXIT1_DR,
        ST_PAUSE_DR,
        ST_EXIT2_DR,
        ST_UPDATE_DR,
        ST_SELECT_IR_SCAN,
        ST_CAPTURE_IR,
        ST_SHIFT_IR,
        ST_EXIT1_IR,
        ST_PAUSE_IR,
        ST_EXIT2_IR,
        ST_UPDATE_IR
    } tap_state_e;

    // Decoded instructions, all others select BYPASS
    typedef enum logic [`DTM_IR_W-1:0] {
        IR_IDCODE = `DTM_IR_W'h01,
        IR_DTMCS  = `DTM_IR_W'h10,
        IR_DMI    = `DTM_IR_W'h11,
        IR_BYPASS = `DTM_IR_W'h1F
    } ir_e;

    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    // Sticky DMI status, also the op value seen at capture
    typedef enum logic [1:0] {
        STAT_OK     = 2'd0,
        STAT_FAILED = 2'd2,
        STAT_BUSY   = 2'd3
    } dmi_stat_e;

    typedef struct packed {
        logic [`DTM_IR_W-1:0] ir;           // Active instruction
        logic                 capture_dr;
        logic                 shift_dr;
        logic                 update_dr;
        logic                 shift_ir;
    } tap_ctrl_t;

    // Scan layout, op sits at the LSB end and leaves first
    typedef struct packed {
        logic [`DTM_ABITS-1:0]  addr;
        logic [`DTM_DATA_W-1:0] data;
        logic [1:0]             op;         // Holds 3 for busy at capture
    } dmi_word_t;

    typedef struct packed {
        logic                   rw;         // 1 write, 0 read
        logic [`DTM_ABITS-1:0]  addr;
        logic [`DTM_DATA_W-1:0] wdata;
    } dmbus_cmd_t;

    typedef struct packed {
        logic [`DTM_DATA_W-1:0] rdata;
        logic                   err;
    } dmbus_rsp_t;

    typedef struct packed {
        logic tdo;                          // Chain LSB
        logic sel;                          // Chain picked by the IR
    } dr_out_t;

endpackage

`default_nettype wire

// File: rtl/tap_controller.sv
// JTAG TAP state machine with the instruction register, feeds decoded scan flags to the DR blocks
`timescale 1ns/10ps
`default_nettype none
`include "dtm_defs.svh"

module tap_controller
(
    input  wire               TCK,
    input  wire               res_tap_async,
    input  wire               tms,
    input  wire               tdi,
    output dtm_pkg::tap_ctrl_t tap_ctrl,
    output logic              ir_lsb
);

    dtm_pkg::tap_state_e  state;
    dtm_pkg::tap_state_e  state_nxt;
    logic [`DTM_IR_W-1:0] ir_sft;           // IR shift stage
    logic [`DTM_IR_W-1:0] ir_reg;           // Instruction in force

    //--------------------------------------------------------------------------
    // State machine
    //--------------------------------------------------------------------------
    always_comb
    begin
        case (state)
            dtm_pkg::ST_TEST_LOGIC_RESET: state_nxt = tms ? state : dtm_pkg::ST_RUN_TEST_IDLE;
            dtm_pkg::ST_RUN_TEST_IDLE:    state_nxt = tms ? dtm_pkg::ST_SELECT_DR_SCAN : state;
            // DR column
            dtm_pkg::ST_SELECT_DR_SCAN:   state_nxt = tms ? dtm_pkg::ST_SELECT_IR_SCAN
                                                          : dtm_pkg::ST_CAPTURE_DR;
            dtm_pkg::ST_CAPTURE_DR:       state_nxt = tms ? dtm_pkg::ST_EXIT1_DR : dtm_pkg::ST_SHIFT_DR;
            dtm_pkg::ST_SHIFT_DR:         state_nxt = tms ? dtm_pkg::ST_EXIT1_DR : state;
            dtm_pkg::ST_EXIT1_DR:         state_nxt = tms ? dtm_pkg::ST_UPDATE_DR : dtm_pkg::ST_PAUSE_DR;
            dtm_pkg::ST_PAUSE_DR:         state_nxt = tms ? dtm_pkg::ST_EXIT2_DR : state;
            dtm_pkg::ST_EXIT2_DR:         state_nxt = tms ? dtm_pkg::ST_UPDATE_DR : dtm_pkg::ST_SHIFT_DR;
            dtm_pkg::ST_UPDATE_DR:        state_nxt = tms ? dtm_pkg::ST_SELECT_DR_SCAN
                                                          : dtm_pkg::ST_RUN_TEST_IDLE;
            // IR column
            dtm_pkg::ST_SELECT_IR_SCAN:   state_nxt = tms ? dtm_pkg::ST_TEST_LOGIC_RESET
                                                          : dtm_pkg::ST_CAPTURE_IR;
            dtm_pkg::ST_CAPTURE_IR:       state_nxt = tms ? dtm_pkg::ST_EXIT1_IR : dtm_pkg::ST_SHIFT_IR;
            dtm_pkg::ST_SHIFT_IR:         state_nxt = tms ? dtm_pkg::ST_EXIT1_IR : state;
            dtm_pkg::ST_EXIT1_IR:         state_nxt = tms ? dtm_pkg::ST_UPDATE_IR : dtm_pkg::ST_PAUSE_IR;
            dtm_pkg::ST_PAUSE_IR:         state_nxt = tms ? dtm_pkg::ST_EXIT2_IR : state;
            dtm_pkg::ST_EXIT2_IR:         state_nxt = tms ? dtm_pkg::ST_UPDATE_IR : dtm_pkg::ST_SHIFT_IR;
            dtm_pkg::ST_UPDATE_IR:        state_nxt = tms ? dtm_pkg::ST_SELECT_DR_SCAN
                                                          : dtm_pkg::ST_RUN_TEST_IDLE;
        endcase
    end

    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
            state <= dtm_pkg::ST_TEST_LOGIC_RESET;
        else
            state <= state_nxt;
    end

    //--------------------------------------------------------------------------
    // Instruction register
    //--------------------------------------------------------------------------
    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
            ir_sft <= '0;
        else if (state == dtm_pkg::ST_CAPTURE_IR)
            ir_sft <= `DTM_IR_W'(1);                // Fixed 01 pattern
        else if (state == dtm_pkg::ST_SHIFT_IR)
            ir_sft <= {tdi, ir_sft[`DTM_IR_W-1:1]}; // LSB first
    end

    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
            ir_reg <= dtm_pkg::IR_IDCODE;
        else if (state == dtm_pkg::ST_TEST_LOGIC_RESET)
            ir_reg <= dtm_pkg::IR_IDCODE;           // TLR reloads IDCODE
        else if (state == dtm_pkg::ST_UPDATE_IR)
            ir_reg <= ir_sft;
    end

    // Flags straight from the current state
    always_comb
    begin
        tap_ctrl.ir         = ir_reg;
        tap_ctrl.capture_dr = (state == dtm_pkg::ST_CAPTURE_DR);
        tap_ctrl.shift_dr   = (state == dtm_pkg::ST_SHIFT_DR);
        tap_ctrl.update_dr  = (state == dtm_pkg::ST_UPDATE_DR);
        tap_ctrl.shift_ir   = (state == dtm_pkg::ST_SHIFT_IR);
    end

    assign ir_lsb = ir_sft[0];

    // Five TMS-high edges in a row land in Test-Logic-Reset from any state
    a_tms_reset: assert property (@(posedge TCK) disable iff (res_tap_async)
        tms && $past(tms, 1) && $past(tms, 2) && $past(tms, 3) && $past(tms, 4)
        |=> (state == dtm_pkg::ST_TEST_LOGIC_RESET));

endmodule

`default_nettype wire

// File: rtl/dtm_status_regs.sv
// BYPASS, IDCODE and DTMCS data registers of the DTM, also raises the dmireset pulse
`timescale 1ns/10ps
`default_nettype none
`include "dtm_defs.svh"

module dtm_status_regs
(
    input  wire                TCK,
    input  wire                res_tap_async,
    input  wire                tdi,
    input  wire dtm_pkg::tap_ctrl_t tap_ctrl,
    input  wire dtm_pkg::dmi_stat_e dmi_stat,
    output dtm_pkg::dr_out_t   status_out,
    output logic               dmi_reset
);

    logic        bypass_q;                   // One-bit BYPASS stage
    logic [31:0] idcode_sft;
    logic [31:0] dtmcs_sft;
    logic [31:0] dtmcs_cap;                  // DTMCS value at Capture-DR
    logic [1:0]  dmistat;
    logic        sel_idcode;
    logic        sel_dtmcs;
    logic        sel_bypass;

    assign sel_idcode = (tap_ctrl.ir == dtm_pkg::IR_IDCODE);
    assign sel_dtmcs  = (tap_ctrl.ir == dtm_pkg::IR_DTMCS);
    assign sel_bypass = !sel_idcode && !sel_dtmcs && (tap_ctrl.ir != dtm_pkg::IR_DMI);

    always_comb
    begin
        case (dmi_stat)
            dtm_pkg::STAT_OK:   dmistat = 2'd0;
            dtm_pkg::STAT_BUSY: dmistat = 2'd3;
            default:            dmistat = 2'd2;     // Any other error reads failed
        endcase
    end

    // Reset bits read back as zero
    assign dtmcs_cap = {14'h0, 3'b000, 3'(`DTM_IDLE_HINT), dmistat,
                        6'(`DTM_ABITS), 4'(`DTM_VERSION)};

    //--------------------------------------------------------------------------
    // Shift chains, LSB first
    //--------------------------------------------------------------------------
    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
        begin
            bypass_q   <= 1'b0;
            idcode_sft <= '0;
            dtmcs_sft  <= '0;
        end
        else if (tap_ctrl.capture_dr)
        begin
            if (sel_bypass) bypass_q   <= 1'b0;
            if (sel_idcode) idcode_sft <= `DTM_IDCODE;
            if (sel_dtmcs)  dtmcs_sft  <= dtmcs_cap;
        end
        else if (tap_ctrl.shift_dr)
        begin
            if (sel_bypass) bypass_q   <= tdi;
            if (sel_idcode) idcode_sft <= {tdi, idcode_sft[31:1]};
            if (sel_dtmcs)  dtmcs_sft  <= {tdi, dtmcs_sft[31:1]};
        end
    end

    // Everything but DMI lives here
    assign status_out = '{tdo: sel_idcode ? idcode_sft[0] :
                               sel_dtmcs  ? dtmcs_sft[0]  : bypass_q,
                          sel: sel_idcode || sel_dtmcs || sel_bypass};

    assign dmi_reset = tap_ctrl.update_dr && sel_dtmcs && dtmcs_sft[16]; // dmireset bit

endmodule

`default_nettype wire

// File: rtl/dmi_access.sv
// DMI scan register of the DTM, launches one bus command at a time and keeps the sticky status
`timescale 1ns/10ps
`default_nettype none

module dmi_access
(
    input  wire                 TCK,
    input  wire                 res_tap_async,
    input  wire                 tdi,
    input  wire dtm_pkg::tap_ctrl_t tap_ctrl,
    input  wire                 dmi_reset,
    output dtm_pkg::dr_out_t    dmi_out,
    output dtm_pkg::dmi_stat_e  dmi_stat,
    output logic                dmbus_req,
    output dtm_pkg::dmbus_cmd_t dmbus_cmd,
    input  wire                 dmbus_ack,
    input  wire dtm_pkg::dmbus_rsp_t dmbus_rsp
);

    dtm_pkg::dmi_word_t  dmi_sft;            // Scan chain
    dtm_pkg::dmi_word_t  cap_word;           // Loaded at Capture-DR
    dtm_pkg::dmbus_rsp_t rsp_q;              // Response until retired
    logic                sel_dmi;
    logic                upd_dmi;
    logic                cap_dmi;
    logic                cmd_busy;           // Launch to retire
    logic                cmd_done;           // Ack seen
    logic                launch;
    logic                retire;
    logic                busy_hit;
    logic                bus_end;

    assign sel_dmi = (tap_ctrl.ir == dtm_pkg::IR_DMI);
    assign upd_dmi = sel_dmi && tap_ctrl.update_dr;
    assign cap_dmi = sel_dmi && tap_ctrl.capture_dr;
    assign bus_end = dmbus_req && dmbus_ack;

    // Read or write with a clean status and an idle bus
    assign launch   = upd_dmi && (dmi_stat == dtm_pkg::STAT_OK) && !cmd_busy && !dmbus_ack
                   && ((dmi_sft.op == dtm_pkg::DMI_READ) || (dmi_sft.op == dtm_pkg::DMI_WRITE));
    assign busy_hit = upd_dmi && (cmd_busy || dmbus_ack);  // Update while still in flight
    assign retire   = cap_dmi && (dmi_stat == dtm_pkg::STAT_OK) && cmd_busy && cmd_done;

    //--------------------------------------------------------------------------
    // Capture value
    //--------------------------------------------------------------------------
    always_comb
    begin
        cap_word = '0;
        if (dmi_stat != dtm_pkg::STAT_OK)
            cap_word.op = dmi_stat;                     // Sticky status, zero data
        else if (cmd_busy && !cmd_done)
            cap_word.op = dtm_pkg::STAT_BUSY;
        else if (cmd_busy)
        begin
            cap_word.addr = dmbus_cmd.addr;
            cap_word.data = dmbus_cmd.rw ? dmbus_cmd.wdata : rsp_q.rdata;
            cap_word.op   = rsp_q.err ? dtm_pkg::STAT_FAILED : dtm_pkg::STAT_OK;
        end
    end

    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
            dmi_sft <= '0;
        else if (cap_dmi)
            dmi_sft <= cap_word;
        else if (sel_dmi && tap_ctrl.shift_dr)
            dmi_sft <= {tdi, dmi_sft[$bits(dmi_sft)-1:1]};
    end

    assign dmi_out = '{tdo: dmi_sft[0], sel: sel_dmi};

    //--------------------------------------------------------------------------
    // Bus handshake, four phase
    //--------------------------------------------------------------------------
    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
        begin
            dmbus_req <= 1'b0;
            cmd_busy  <= 1'b0;
            cmd_done  <= 1'b0;
        end
        else if (launch)
        begin
            dmbus_req <= 1'b1;
            cmd_busy  <= 1'b1;
        end
        else if (bus_end)
        begin
            dmbus_req <= 1'b0;                          // Drop req after ack
            cmd_done  <= 1'b1;
        end
        else if (retire)
        begin
            cmd_busy <= 1'b0;
            cmd_done <= 1'b0;
        end
    end

    always_ff @(posedge TCK)
    begin
        if (launch)
        begin
            dmbus_cmd.rw    <= (dmi_sft.op == dtm_pkg::DMI_WRITE);
            dmbus_cmd.addr  <= dmi_sft.addr;
            dmbus_cmd.wdata <= dmi_sft.data;
        end
        if (bus_end)
            rsp_q <= dmbus_rsp;
    end

    // Sticky status, first error wins until dmireset
    always_ff @(posedge TCK, posedge res_tap_async)
    begin
        if (res_tap_async)
            dmi_stat <= dtm_pkg::STAT_OK;
        else if (dmi_reset)
            dmi_stat <= dtm_pkg::STAT_OK;
        else if (dmi_stat == dtm_pkg::STAT_OK)
        begin
            if (busy_hit || (cap_dmi && cmd_busy && !cmd_done))
                dmi_stat <= dtm_pkg::STAT_BUSY;
            else if (retire && rsp_q.err)
                dmi_stat <= dtm_pkg::STAT_FAILED;
        end
    end

    a_cmd_stable: assert property (@(posedge TCK) disable iff (res_tap_async)
        dmbus_req |=> !dmbus_req || $stable(dmbus_cmd));

    // Ack already low at the edge that raised req
    a_req_rise: assert property (@(posedge TCK) disable iff (res_tap_async)
        $rose(dmbus_req) |-> !$past(dmbus_ack));

endmodule

`default_nettype wire

// File: rtl/tdo_driver.sv
// Falling-edge TDO stage of the DTM, picks the IR or the selected data chain while shifting
`timescale 1ns/10ps
`default_nettype none

module tdo_driver
(
    input  wire                     TCK,
    input  wire                     res_tap_async,
    input  wire dtm_pkg::tap_ctrl_t tap_ctrl,
    input  wire                     ir_lsb,
    input  wire dtm_pkg::dr_out_t   status_out,
    input  wire dtm_pkg::dr_out_t   dmi_out,
    output logic                    tdo_d,
    output logic                    tdo_e
);

    always_ff @(negedge TCK, posedge res_tap_async)     // Half cycle ahead of the sampling edge
    begin
        if (res_tap_async)
        begin
            tdo_d <= 1'b1;
            tdo_e <= 1'b0;
        end
        else if (tap_ctrl.shift_ir)
        begin
            tdo_d <= ir_lsb;
            tdo_e <= 1'b1;
        end
        else if (tap_ctrl.shift_dr)
        begin
            tdo_d <= (status_out.sel && status_out.tdo) || (dmi_out.sel && dmi_out.tdo);
            tdo_e <= 1'b1;
        end
        else
        begin
            tdo_d <= 1'b1;                              // Idle high, driver off
            tdo_e <= 1'b0;
        end
    end

    // Exactly one chain claims the IR
    a_one_chain: assert property (@(posedge TCK) disable iff (res_tap_async)
        tap_ctrl.shift_dr |-> $onehot({status_out.sel, dmi_out.sel}));

endmodule

`default_nettype wire

// File: rtl/dtm_jtag_top.sv
// Top level of the JTAG debug transport module, ties TAP, data registers and TDO stage together
`timescale 1ns/10ps
`default_nettype none

module dtm_jtag_top
(
    input  wire                      TCK,
    input  wire                      res_tap_async,
    input  wire                      tms,
    input  wire                      tdi,
    output wire                      tdo_d,
    output wire                      tdo_e,
    output wire                      dmbus_req,
    output wire dtm_pkg::dmbus_cmd_t dmbus_cmd,
    input  wire                      dmbus_ack,
    input  wire dtm_pkg::dmbus_rsp_t dmbus_rsp
);

    dtm_pkg::tap_ctrl_t tap_ctrl;            // Shared scan control
    dtm_pkg::dr_out_t   status_out;
    dtm_pkg::dr_out_t   dmi_out;
    dtm_pkg::dmi_stat_e dmi_stat;
    logic               ir_lsb;
    logic               dmi_reset;

    tap_controller tap_controller_inst
    (
        .TCK           (TCK),
        .res_tap_async (res_tap_async),
        .tms           (tms),
        .tdi           (tdi),
        .tap_ctrl      (tap_ctrl),
        .ir_lsb        (ir_lsb)
    );

    // Data registers side by side
    dtm_status_regs dtm_status_regs_inst
    (
        .TCK           (TCK),
        .res_tap_async (res_tap_async),
        .tdi           (tdi),
        .tap_ctrl      (tap_ctrl),
        .dmi_stat      (dmi_stat),
        .status_out    (status_out),
        .dmi_reset     (dmi_reset)
    );

    dmi_access dmi_access_inst
    (
        .TCK           (TCK),
        .res_tap_async (res_tap_async),
        .tdi           (tdi),
        .tap_ctrl      (tap_ctrl),
        .dmi_reset     (dmi_reset),
        .dmi_out       (dmi_out),
        .dmi_stat      (dmi_stat),
        .dmbus_req     (dmbus_req),
        .dmbus_cmd     (dmbus_cmd),
        .dmbus_ack     (dmbus_ack),
        .dmbus_rsp     (dmbus_rsp)
    );

    tdo_driver tdo_driver_inst
    (
        .TCK           (TCK),
        .res_tap_async (res_tap_async),
        .tap_ctrl      (tap_ctrl),
        .ir_lsb        (ir_lsb),
        .status_out    (status_out),
        .dmi_out       (dmi_out),
        .tdo_d         (tdo_d),
        .tdo_e         (tdo_e)
    );

endmodule

`default_nettype wire

// File: bench/tb_dtm_jtag.sv
// Testbench for the JTAG DTM top level, random DMI traffic checked against a bus memory model
`timescale 1ns/10ps
`default_nettype none
`include "dtm_defs.svh"

module tb_dtm_jtag;

    localparam int N_ACCESS   = 24;                 // Random DMI accesses
    localparam int SCAN_CYC   = 55;                 // Longest scan plus idle
    localparam int MAX_CYCLES = (N_ACCESS + 30) * SCAN_CYC * 2 + 16;

    logic                TCK;
    logic                res_tap_async;
    logic                tms;
    logic                tdi;
    wire                 tdo_d;
    wire                 tdo_e;
    wire                 dmbus_req;
    dtm_pkg::dmbus_cmd_t dmbus_cmd;
    logic                dmbus_ack;
    dtm_pkg::dmbus_rsp_t dmbus_rsp;

    logic [31:0]         rng;                       // LCG state
    logic [31:0]         mem [0:(1<<`DTM_ABITS)-1]; // Bus memory model
    dtm_pkg::dmbus_cmd_t exp_cmd;
    logic                hold_ack;                  // Responder back-pressure
    int                  req_count;
    int                  cycles;

    dtm_jtag_top dtm_jtag_top_inst
    (
        .TCK           (TCK),
        .res_tap_async (res_tap_async),
        .tms           (tms),
        .tdi           (tdi),
        .tdo_d         (tdo_d),
        .tdo_e         (tdo_e),
        .dmbus_req     (dmbus_req),
        .dmbus_cmd     (dmbus_cmd),
        .dmbus_ack     (dmbus_ack),
        .dmbus_rsp     (dmbus_rsp)
    );

    initial TCK = 1'b0;
    always #2 TCK = ~TCK;

    function automatic logic [31:0] next_random();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // DTMCS layout: version [3:0], abits [9:4], dmistat [11:10], idle [14:12]
    function automatic logic [31:0] dtmcs_value(input logic [1:0] stat);
        return (32'(`DTM_IDLE_HINT) << 12) | (32'(stat) << 10)
             | (32'(`DTM_ABITS) << 4) | 32'(`DTM_VERSION);
    endfunction

    //--------------------------------------------------------------------------
    // Failure reporting and compare tasks
    //--------------------------------------------------------------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input dtm_pkg::dmi_word_t got, input dtm_pkg::dmi_word_t exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %0t dmi_word got %h expected %h", $time, got, exp));
    endtask

    task automatic check_dtmcs(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_bus(input dtm_pkg::dmbus_cmd_t got, input dtm_pkg::dmbus_cmd_t exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %0t dmbus_cmd got %h expected %h", $time, got, exp));
    endtask

    task automatic check_ir(input logic [`DTM_IR_W-1:0] got);
        if (got !== `DTM_IR_W'(1))
            report_fail($sformatf("[FAIL] %0t ir_capture got %h expected 01", $time, got));
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    //--------------------------------------------------------------------------
    // TAP driving
    //--------------------------------------------------------------------------
    task automatic tck_step(input logic tms_v, input logic tdi_v,
                            output logic tdo_v, output logic tdoe_v);
        tms = tms_v;
        tdi = tdi_v;
        @(posedge TCK);
        tdo_v  = tdo_d;                             // Stable since falling edge
        tdoe_v = tdo_e;
        #0.5;
    endtask

    task automatic idle(input int n);
        logic b;
        logic e;
        repeat (n)
        begin
            tck_step(1'b0, 1'b0, b, e);
            check_pin("tdo_e", e, 1'b0);            // Driver off in Run-Test/Idle
            check_pin("tdo_d", b, 1'b1);
        end
    endtask

    // Starts and ends in Run-Test/Idle
    task automatic dr_scan(input logic [63:0] din, input int len, output logic [63:0] dout);
        logic b;
        logic e;
        dout = '0;
        tck_step(1'b1, 1'b0, b, e);                 // Select-DR
        tck_step(1'b0, 1'b0, b, e);                 // Capture-DR
        tck_step(1'b0, 1'b0, b, e);                 // Shift-DR
        for (int i = 0; i < len; i++)
        begin
            tck_step(i == len - 1, din[i], b, e);
            dout[i] = b;
            check_pin("tdo_e", e, 1'b1);
        end
        tck_step(1'b1, 1'b0, b, e);                 // Update-DR
        tck_step(1'b0, 1'b0, b, e);
    endtask

    task automatic ir_scan(input logic [`DTM_IR_W-1:0] din, output logic [`DTM_IR_W-1:0] dout);
        logic b;
        logic e;
        tck_step(1'b1, 1'b0, b, e);
        tck_step(1'b1, 1'b0, b, e);                 // Select-IR
        tck_step(1'b0, 1'b0, b, e);
        tck_step(1'b0, 1'b0, b, e);
        for (int i = 0; i < `DTM_IR_W; i++)
        begin
            tck_step(i == `DTM_IR_W - 1, din[i], b, e);
            dout[i] = b;
            check_pin("tdo_e", e, 1'b1);
        end
        tck_step(1'b1, 1'b0, b, e);                 // Update-IR
        tck_step(1'b0, 1'b0, b, e);
    endtask

    task automatic set_ir(input logic [`DTM_IR_W-1:0] ir);
        logic [`DTM_IR_W-1:0] cap;
        ir_scan(ir, cap);
        check_ir(cap);
    endtask

    // One DMI scan, its capture and the number of bus requests it starts
    task automatic run_dmi(input dtm_pkg::dmi_word_t word, input dtm_pkg::dmi_word_t exp,
                           input int launches);
        logic [63:0] dout;
        int          cnt;
        cnt = req_count;
        if (launches > 0)
            exp_cmd = '{rw: word.op == dtm_pkg::DMI_WRITE, addr: word.addr, wdata: word.data};
        dr_scan(64'(word), $bits(word), dout);
        check_word(dtm_pkg::dmi_word_t'(dout[$bits(word)-1:0]), exp);
        idle(8);
        if (req_count != cnt + launches)
            report_fail($sformatf("Expected %0d new bus requests, saw %0d", launches,
                                  req_count - cnt));
    endtask

    task automatic dtmcs_access(input logic [31:0] din, input logic [1:0] stat);
        logic [63:0] dout;
        set_ir(dtm_pkg::IR_DTMCS);
        dr_scan(64'(din), 32, dout);
        check_dtmcs("dtmcs", dout[31:0], dtmcs_value(stat));
    endtask

    //--------------------------------------------------------------------------
    // Bus responder, four-phase handshake
    //--------------------------------------------------------------------------
    initial
    begin
        logic resp_active;
        logic req_prev;
        int   wait_left;
        dmbus_ack   = 1'b0;
        dmbus_rsp   = '0;
        resp_active = 1'b0;
        req_prev    = 1'b0;
        wait_left   = 0;
        forever
        begin
            @(posedge TCK);
            #0.5;
            if (!res_tap_async)
            begin
                if (dmbus_req && !req_prev)
                    req_count++;
                req_prev = dmbus_req;
                if (dmbus_ack)
                begin
                    if (!dmbus_req)
                        dmbus_ack = 1'b0;           // Req seen low
                end
                else if (dmbus_req && !hold_ack)
                begin
                    if (!resp_active)
                    begin
                        resp_active = 1'b1;
                        wait_left   = 1 + int'(next_random() % 3);
                        check_bus(dmbus_cmd, exp_cmd);
                    end
                    wait_left--;
                    if (wait_left == 0)
                    begin
                        resp_active     = 1'b0;
                        dmbus_rsp.err   = dmbus_cmd.addr[`DTM_ABITS-1];  // Upper half errors
                        dmbus_rsp.rdata = '0;
                        if (!dmbus_rsp.err && dmbus_cmd.rw)
                            mem[dmbus_cmd.addr] = dmbus_cmd.wdata;
                        else if (!dmbus_rsp.err)
                            dmbus_rsp.rdata = mem[dmbus_cmd.addr];
                        dmbus_ack = 1'b1;
                    end
                end
            end
        end
    end

    // Run limit
    always @(posedge TCK)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    //--------------------------------------------------------------------------
    // Test sequence
    //--------------------------------------------------------------------------
    initial
    begin
        logic [63:0]          dout;
        logic [31:0]          stream;
        logic [31:0]          r;
        logic [`DTM_IR_W-1:0] ir_rand;
        logic [`DTM_ABITS-1:0] a;
        logic [`DTM_ABITS-1:0] a_held;
        dtm_pkg::dmi_word_t   w;
        dtm_pkg::dmi_word_t   prev;
        rng           = 32'hbece_4d9e;
        res_tap_async = 1'b1;
        tms           = 1'b1;
        tdi           = 1'b0;
        hold_ack      = 1'b0;
        req_count     = 0;
        cycles        = 0;
        exp_cmd       = '0;
        for (int i = 0; i < (1 << `DTM_ABITS); i++)
            mem[i] = 32'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f;   // Unique per address
        repeat (16) @(posedge TCK);
        #0.5;
        res_tap_async = 1'b0;
        idle(2);

        // Reset values, IDCODE is live without an IR scan
        dr_scan(64'h0, 32, dout);
        check_dtmcs("idcode", dout[31:0], `DTM_IDCODE);

        // BYPASS with an undecoded instruction
        ir_rand = `DTM_IR_W'(next_random());
        while (ir_rand == dtm_pkg::IR_IDCODE || ir_rand == dtm_pkg::IR_DTMCS
               || ir_rand == dtm_pkg::IR_DMI)
            ir_rand = `DTM_IR_W'(next_random());
        set_ir(ir_rand);
        stream = next_random();
        dr_scan(64'(stream), 32, dout);
        check_dtmcs("bypass", dout[31:0], {stream[30:0], 1'b0});

        dtmcs_access(32'h0, 2'd0);

        // Random writes and reads
        set_ir(dtm_pkg::IR_DMI);
        prev = '0;
        for (int i = 0; i < N_ACCESS; i++)
        begin
            r      = next_random();
            w.addr = `DTM_ABITS'(r) & `DTM_ABITS'(7'h3f);
            w.data = next_random();
            w.op   = r[16] ? dtm_pkg::DMI_WRITE : dtm_pkg::DMI_READ;
            run_dmi(w, prev, 1);
            prev = '{addr: w.addr, data: r[16] ? w.data : mem[w.addr], op: 2'd0};
        end
        run_dmi('0, prev, 0);

        // Error path and dmireset
        a = `DTM_ABITS'(next_random()) | `DTM_ABITS'(7'h40);
        run_dmi('{addr: a, data: 32'h0, op: dtm_pkg::DMI_READ}, '0, 1);
        run_dmi('0, '{addr: a, data: 32'h0, op: 2'd2}, 0);
        run_dmi('{addr: 7'h05, data: 32'h1234, op: dtm_pkg::DMI_WRITE}, '{default: '0, op: 2'd2}, 0);
        dtmcs_access(32'h0, 2'd2);
        dtmcs_access(32'h0001_0000, 2'd2);
        set_ir(dtm_pkg::IR_DMI);
        run_dmi('{addr: 7'h05, data: 32'h0, op: dtm_pkg::DMI_READ}, '0, 1);
        run_dmi('0, '{addr: 7'h05, data: mem[5], op: 2'd0}, 0);

        // Busy with ack withheld
        hold_ack = 1'b1;
        a_held   = 7'h0a;
        run_dmi('{addr: a_held, data: 32'h0, op: dtm_pkg::DMI_READ}, '0, 1);
        run_dmi('0, '{default: '0, op: 2'd3}, 0);
        run_dmi('{addr: 7'h0b, data: 32'h0, op: dtm_pkg::DMI_READ}, '{default: '0, op: 2'd3}, 0);
        hold_ack = 1'b0;
        idle(8);
        dtmcs_access(32'h0, 2'd3);
        dtmcs_access(32'h0001_0000, 2'd3);
        set_ir(dtm_pkg::IR_DMI);
        run_dmi('{addr: 7'h0c, data: 32'h0, op: dtm_pkg::DMI_READ},
                '{addr: a_held, data: mem[a_held], op: 2'd0}, 1);
        run_dmi('0, '{addr: 7'h0c, data: mem[12], op: 2'd0}, 0);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
rtl/dtm_pkg.sv
rtl/tap_controller.sv
rtl/dtm_status_regs.sv
rtl/dmi_access.sv
rtl/tdo_driver.sv
rtl/dtm_jtag_top.sv
bench/tb_dtm_jtag.sv

// File: Makefile
# Verilator build and run of the JTAG DTM testbench

VERILATOR ?= verilator
TOP       ?= tb_dtm_jtag
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' files.f) include/dtm_defs.svh

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): files.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f files.f --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
